//--- hdl/rv_fetch_macros.svh
`ifndef RV_FETCH_MACROS_SVH
`define RV_FETCH_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Fetch front end constants
//////////////////////////////////////////////////////////////////////

// Word address of the first fetch after reset
`define FETCH_RESET_WORD 30'h0000_0000

// addi x0, x0, 0 without its two low bits
// Marks an empty slot on the instruction output
`define INSTR_NOP 30'h0000_0004

`endif

//--- hdl/rv_fetch_pkg.sv
package rv_fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction and cache word types
    //////////////////////////////////////////////////////////////////////

    // Bits 31:2 of an uncompressed instruction
    // The low two bits are always 11 and never carried
    typedef logic [31:2] instr_t;

    // One cache word
    // Whole for an aligned long instruction, by halves for compressed
    // instructions and for long ones that straddle two words
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [15:0] hi;
            logic [15:0] lo;
        } halves;
    } fetch_word_u;

endpackage

//--- hdl/rvc_expander.sv
module rvc_expander (
    input  logic [15:0]          instr_i,
    output rv_fetch_pkg::instr_t instr_o
);

    // Major opcodes, bits 6:2
    localparam logic [4:0] OP_LOAD   = 5'b00000;
    localparam logic [4:0] OP_STORE  = 5'b01000;
    localparam logic [4:0] OP_IMM    = 5'b00100;
    localparam logic [4:0] OP_LUI    = 5'b01101;
    localparam logic [4:0] OP_REG    = 5'b01100;
    localparam logic [4:0] OP_JAL    = 5'b11011;
    localparam logic [4:0] OP_BRANCH = 5'b11000;

    logic [2:0]  funct3;
    logic [4:0]  rd_full;
    logic [4:0]  rs2_full;
    logic [4:0]  rd_prime;
    logic [4:0]  rs1_prime;
    logic [11:0] imm_ci;

    // Register fields, primed ones map onto x8..x15
    assign funct3    = instr_i[15:13];
    assign rd_full   = instr_i[11:7];
    assign rs2_full  = instr_i[6:2];
    assign rd_prime  = {2'b01, instr_i[4:2]};
    assign rs1_prime = {2'b01, instr_i[9:7]};

    // Sign extended 6-bit immediate of the CI format
    assign imm_ci = {{7{instr_i[12]}}, instr_i[6:2]};

    //////////////////////////////////////////////////////////////////////
    // Quadrant and funct3 decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Anything not listed below is illegal downstream
        instr_o = '0;
        case (instr_i[1:0])
            2'b00: begin
                case (funct3)
                    // C.LW
                    3'b010: instr_o = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                                       rs1_prime, 3'b010, rd_prime, OP_LOAD};
                    // C.SW
                    3'b110: instr_o = {5'b0, instr_i[5], instr_i[12], rd_prime, rs1_prime,
                                       3'b010, instr_i[11:10], instr_i[6], 2'b00, OP_STORE};
                    default: instr_o = '0;
                endcase
            end
            2'b01: begin
                case (funct3)
                    // C.ADDI
                    3'b000: instr_o = {imm_ci, rd_full, 3'b000, rd_full, OP_IMM};
                    // C.LI
                    3'b010: instr_o = {imm_ci, 5'd0, 3'b000, rd_full, OP_IMM};
                    3'b011: begin
                        // C.LUI, rd of x2 is C.ADDI16SP and stays illegal
                        if (rd_full != 5'd2) begin
                            instr_o = {{14{instr_i[12]}}, instr_i[12], instr_i[6:2],
                                       rd_full, OP_LUI};
                        end
                    end
                    // C.J as jal x0 with the scrambled offset put back in order
                    3'b101: instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                                       instr_i[7], instr_i[2], instr_i[11], instr_i[5:3],
                                       instr_i[12], {8{instr_i[12]}}, 5'd0, OP_JAL};
                    // C.BEQZ as beq rs1', x0
                    3'b110: instr_o = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2], 5'd0,
                                       rs1_prime, 3'b000, instr_i[11:10], instr_i[4:3],
                                       instr_i[12], OP_BRANCH};
                    default: instr_o = '0;
                endcase
            end
            2'b10: begin
                case (funct3)
                    3'b000: begin
                        // C.SLLI, shamt[5] set is reserved on RV32
                        if (!instr_i[12]) begin
                            instr_o = {7'b0, instr_i[6:2], rd_full, 3'b001, rd_full, OP_IMM};
                        end
                    end
                    3'b100: begin
                        // rs2 of x0 here is C.JR, C.JALR or C.EBREAK
                        if (rs2_full != 5'd0) begin
                            if (instr_i[12]) begin
                                // C.ADD
                                instr_o = {7'b0, rs2_full, rd_full, 3'b000, rd_full, OP_REG};
                            end else begin
                                // C.MV
                                instr_o = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, OP_REG};
                            end
                        end
                    end
                    default: instr_o = '0;
                endcase
            end
            default: instr_o = '0;
        endcase
    end

endmodule

//--- hdl/fetch_address_gen.sv
`include "rv_fetch_macros.svh"

module fetch_address_gen (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        stall_i,
    input  logic        cache_blocking_n_i,
    input  logic        branch_i,
    input  logic [31:2] branch_word_i,
    input  logic        counter_inc_i,
    input  logic        addr_next_i,
    input  logic        half_sel_i,
    output logic [31:2] fetch_addr_o
);

    logic [31:2] counter_q;
    logic [31:2] counter_plus1;

    assign counter_plus1 = counter_q + 30'd1;

    // Fetch word counter, moves only in accepted cycles
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            counter_q <= `FETCH_RESET_WORD;
        end else if (!stall_i && cache_blocking_n_i) begin
            if (branch_i) begin
                counter_q <= branch_word_i;
            end else if (counter_inc_i) begin
                counter_q <= counter_plus1;
            end
        end
    end

    // Look one word ahead during a delayed read
    assign fetch_addr_o = addr_next_i ? counter_plus1 : counter_q;

endmodule

//--- hdl/fetch_aligner.sv
`include "rv_fetch_macros.svh"

module fetch_aligner (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      stall_i,
    input  logic                      cache_blocking_n_i,
    input  rv_fetch_pkg::fetch_word_u cache_data_i,
    input  logic                      branch_i,
    input  logic                      branch_unaligned_i,
    output logic                      counter_inc_o,
    output logic                      addr_next_o,
    output logic                      half_sel_o,
    output rv_fetch_pkg::instr_t      instr_o,
    output logic                      is_long_o
);

    import rv_fetch_pkg::*;

    logic        upper_half_q;
    logic        delayed_read_q;
    logic [15:2] half_buf_q;
    logic        is_long_lo;
    logic        is_long_hi;
    logic [15:0] rvc_half;
    instr_t      rvc_expanded;
    instr_t      split_instr;

    //////////////////////////////////////////////////////////////////////
    // Word slicing
    //////////////////////////////////////////////////////////////////////

    assign is_long_lo = &cache_data_i.halves.lo[1:0];
    assign is_long_hi = &cache_data_i.halves.hi[1:0];

    // Upper half of the previous word joined with the lower half of this one
    assign split_instr = {cache_data_i.halves.lo, half_buf_q};

    assign rvc_half = upper_half_q ? cache_data_i.halves.hi : cache_data_i.halves.lo;

    rvc_expander i_expander (
        .instr_i (rvc_half),
        .instr_o (rvc_expanded)
    );

    // Select lines to the address generator
    assign counter_inc_o = upper_half_q ? !is_long_hi : (delayed_read_q | is_long_lo);
    assign addr_next_o   = delayed_read_q;
    assign half_sel_o    = upper_half_q | delayed_read_q;

    //////////////////////////////////////////////////////////////////////
    // Alignment FSM and output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            upper_half_q   <= 1'b0;
            delayed_read_q <= 1'b0;
            instr_o        <= `INSTR_NOP;
            is_long_o      <= 1'b0;
        end else if (!stall_i) begin
            if (!cache_blocking_n_i) begin
                // Refused cycle, nothing moves
                instr_o   <= `INSTR_NOP;
                is_long_o <= 1'b0;
            end else if (branch_i) begin
                instr_o        <= `INSTR_NOP;
                is_long_o      <= 1'b0;
                upper_half_q   <= branch_unaligned_i;
                delayed_read_q <= 1'b0;
            end else if (upper_half_q) begin
                upper_half_q <= 1'b0;
                is_long_o    <= 1'b0;
                if (is_long_hi) begin
                    // Only right after a branch into a long instruction
                    instr_o        <= `INSTR_NOP;
                    delayed_read_q <= 1'b1;
                end else begin
                    instr_o        <= rvc_expanded;
                    delayed_read_q <= 1'b0;
                end
            end else if (delayed_read_q) begin
                instr_o   <= split_instr;
                is_long_o <= 1'b1;
                // Another straddling instruction keeps us here
                if (!is_long_hi) begin
                    upper_half_q   <= 1'b1;
                    delayed_read_q <= 1'b0;
                end
            end else begin
                is_long_o <= is_long_lo;
                instr_o   <= is_long_lo ? cache_data_i.word[31:2] : rvc_expanded;
                if (!is_long_lo) begin
                    delayed_read_q <= is_long_hi;
                    upper_half_q   <= !is_long_hi;
                end
            end
        end
    end

    // Upper half kept for a long instruction that continues in the next word
    always_ff @(posedge clk_i) begin
        if (!stall_i && cache_blocking_n_i) begin
            half_buf_q <= cache_data_i.halves.hi[15:2];
        end
    end

endmodule

//--- hdl/rv_fetch_top.sv
module rv_fetch_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    output logic [31:2]               fetch_addr_o,
    input  rv_fetch_pkg::fetch_word_u cache_data_i,
    input  logic                      cache_blocking_n_i,
    input  logic                      stall_i,
    input  logic                      branch_i,
    input  logic [31:1]               branch_target_i,
    output rv_fetch_pkg::instr_t      instr_o,
    output logic                      is_long_o
);

    logic        counter_inc;
    logic        addr_next;
    logic        half_sel;
    logic [31:2] branch_word;
    logic        branch_unaligned;

    // Word part to the counter, halfword bit to the aligner
    assign branch_word      = branch_target_i[31:2];
    assign branch_unaligned = branch_target_i[1];

    fetch_address_gen i_address_gen (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .stall_i            (stall_i),
        .cache_blocking_n_i (cache_blocking_n_i),
        .branch_i           (branch_i),
        .branch_word_i      (branch_word),
        .counter_inc_i      (counter_inc),
        .addr_next_i        (addr_next),
        .half_sel_i         (half_sel),
        .fetch_addr_o       (fetch_addr_o)
    );

    fetch_aligner i_aligner (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .stall_i            (stall_i),
        .cache_blocking_n_i (cache_blocking_n_i),
        .cache_data_i       (cache_data_i),
        .branch_i           (branch_i),
        .branch_unaligned_i (branch_unaligned),
        .counter_inc_o      (counter_inc),
        .addr_next_o        (addr_next),
        .half_sel_o         (half_sel),
        .instr_o            (instr_o),
        .is_long_o          (is_long_o)
    );

endmodule

//--- verif/fetch_checker.sv
`include "rv_fetch_macros.svh"

module fetch_checker (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  logic                 cache_blocking_n_i,
    input  logic                 branch_i,
    input  logic [31:1]          branch_target_i,
    input  rv_fetch_pkg::instr_t instr_i,
    input  logic                 is_long_i,
    input  logic [31:0]          mem_i [256],
    input  int                   test_id_i,
    output int                   checked_o,
    output int                   errors_o
);

    import rv_fetch_pkg::*;

    localparam logic [29:0] RESET_WORD = `FETCH_RESET_WORD;

    logic [8:0]  exp_half;
    logic [8:0]  target_q;
    logic        in_reset_q;
    logic        taken_q;
    logic        fresh_q;

    function automatic string test_label(input int id);
        case (id)
            0: return "reset_idle";
            1: return "aligned_long";
            2: return "compressed";
            3: return "mixed";
            4: return "unaligned_branch";
            5: return "random_stall";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [15:0] half_at(input logic [8:0] idx);
        logic [31:0] w;
        w = mem_i[idx[8:1]];
        return idx[0] ? w[31:16] : w[15:0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference expansion, built from decoded immediates
    //////////////////////////////////////////////////////////////////////

    function automatic logic [29:0] expand_ref(input logic [15:0] h);
        logic [31:0] full;
        logic [11:0] imm6;
        logic [6:0]  mem_off;
        logic [11:0] j_off;
        logic [20:0] jimm;
        logic [8:0]  b_off;
        logic [12:0] bimm;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rdp;
        logic [4:0]  rs1p;
        rd   = h[11:7];
        rs2  = h[6:2];
        rdp  = 5'd8 + h[4:2];
        rs1p = 5'd8 + h[9:7];
        imm6 = {{6{h[12]}}, h[12], h[6:2]};
        mem_off = {h[5], h[12:10], h[6], 2'b00};
        j_off = {h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
        jimm  = {{9{j_off[11]}}, j_off};
        b_off = {h[12], h[6:5], h[2], h[11:10], h[4:3], 1'b0};
        bimm  = {{4{b_off[8]}}, b_off};
        full  = '0;
        case ({h[1:0], h[15:13]})
            5'b00_010: full = {5'b0, mem_off, rs1p, 3'b010, rdp, 7'b0000011};
            5'b00_110: full = {5'b0, mem_off[6:5], rdp, rs1p, 3'b010, mem_off[4:0], 7'b0100011};
            5'b01_000: full = {imm6, rd, 3'b000, rd, 7'b0010011};
            5'b01_010: full = {imm6, 5'd0, 3'b000, rd, 7'b0010011};
            5'b01_011: if (rd != 5'd2) full = {{8{imm6[11]}}, imm6, rd, 7'b0110111};
            5'b01_101: full = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'd0, 7'b1101111};
            5'b01_110: full = {bimm[12], bimm[10:5], 5'd0, rs1p, 3'b000, bimm[4:1], bimm[11],
                               7'b1100011};
            5'b10_000: if (!h[12]) full = {7'b0, rs2, rd, 3'b001, rd, 7'b0010011};
            5'b10_100: begin
                if (rs2 != 5'd0) begin
                    full = {7'b0, rs2, h[12] ? rd : 5'd0, 3'b000, rd, 7'b0110011};
                end
            end
            default: full = '0;
        endcase
        return full[31:2];
    endfunction

    // Halfword walk: {is_long, instruction}
    function automatic logic [30:0] reference_at(input logic [8:0] idx);
        logic [15:0] h0;
        h0 = half_at(idx);
        if (h0[1:0] == 2'b11) begin
            return {1'b1, half_at(idx + 9'd1), h0[15:2]};
        end
        return {1'b0, expand_ref(h0)};
    endfunction

    task automatic check_idle();
        if (instr_i !== `INSTR_NOP || is_long_i !== 1'b0) begin
            errors_o++;
            $display("ERROR test %s: expected instr %h long 0, actual instr %h long %b",
                     test_label(test_id_i), 30'(`INSTR_NOP), instr_i, is_long_i);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sampling and comparison
    //////////////////////////////////////////////////////////////////////

    // Inputs are stable at the rising edge
    always @(posedge clk_i) begin
        in_reset_q <= !rst_i;
        taken_q    <= rst_i && branch_i && !stall_i && cache_blocking_n_i;
        fresh_q    <= rst_i && !stall_i && cache_blocking_n_i;
        target_q   <= branch_target_i[9:1];
    end

    // Registered outputs are stable at the falling edge
    always @(negedge clk_i) begin
        logic [30:0] expected;
        if (in_reset_q) begin
            exp_half  = {RESET_WORD[7:0], 1'b0};
            checked_o = 0;
            errors_o  = 0;
        end else if (taken_q) begin
            exp_half = target_q;
        end else if (fresh_q && instr_i !== `INSTR_NOP) begin
            expected = reference_at(exp_half);
            checked_o++;
            if (expected !== {is_long_i, instr_i}) begin
                errors_o++;
                $display("ERROR test %s: expected instr %h long %b, actual instr %h long %b",
                         test_label(test_id_i), expected[29:0], expected[30],
                         instr_i, is_long_i);
            end
            exp_half = exp_half + (expected[30] ? 9'd2 : 9'd1);
        end
    end

endmodule

//--- verif/tb_rv_fetch.sv
`include "rv_fetch_macros.svh"

module tb_rv_fetch;

    import rv_fetch_pkg::*;

    // Sum of the instruction counts of all tests
    localparam int TOTAL_INSTR = 450;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        cache_blocking_n;
    logic        branch;
    logic [31:1] branch_target;
    logic [31:2] fetch_addr;
    logic [31:0] cache_word;
    instr_t      dut_instr;
    logic        dut_is_long;
    logic [31:0] mem [256];
    logic [15:0] halves [512];
    bit          starts [512];
    int          seed;
    int          test_id;
    int          checked;
    int          errors;
    int          err_base;
    int          failed_tests;

    // Zero latency cache
    assign cache_word = mem[fetch_addr[9:2]];

    rv_fetch_top i_dut (
        .clk_i              (clk),
        .rst_i              (rst),
        .fetch_addr_o       (fetch_addr),
        .cache_data_i       (cache_word),
        .cache_blocking_n_i (cache_blocking_n),
        .stall_i            (stall),
        .branch_i           (branch),
        .branch_target_i    (branch_target),
        .instr_o            (dut_instr),
        .is_long_o          (dut_is_long)
    );

    fetch_checker i_checker (
        .clk_i              (clk),
        .rst_i              (rst),
        .stall_i            (stall),
        .cache_blocking_n_i (cache_blocking_n),
        .branch_i           (branch),
        .branch_target_i    (branch_target),
        .instr_i            (dut_instr),
        .is_long_i          (dut_is_long),
        .mem_i              (mem),
        .test_id_i          (test_id),
        .checked_o          (checked),
        .errors_o           (errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (TOTAL_INSTR * 40) @(posedge clk);
        $display("Run timed out after %0d cycles", TOTAL_INSTR * 40);
        $display("Something failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction generators
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] rvc_word();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  lui_rd;
        logic [5:0]  imm;
        logic [5:0]  lui_imm;
        r       = $random(seed);
        rd      = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
        rs2     = (r[21:17] == 5'd0) ? 5'd5 : r[21:17];
        imm     = r[16:11];
        lui_rd  = (rd == 5'd2) ? 5'd3 : rd;
        lui_imm = (imm == 6'd0) ? 6'd1 : imm;
        case ($unsigned($random(seed)) % 10)
            0: return {3'b000, imm[5], rd, imm[4:0], 2'b01};
            1: return {3'b010, imm[5], rd, imm[4:0], 2'b01};
            2: return {3'b011, lui_imm[5], lui_rd, lui_imm[4:0], 2'b01};
            3: return {3'b000, 1'b0, rd, imm[4:0], 2'b10};
            4: return {3'b010, r[15:13], r[10:8], r[17:16], r[7:5], 2'b00};
            5: return {3'b110, r[15:13], r[10:8], r[17:16], r[7:5], 2'b00};
            6: return {3'b101, r[26:16], 2'b01};
            7: return {3'b110, r[18:16], r[10:8], r[23:19], 2'b01};
            8: return {3'b100, 1'b0, rd, rs2, 2'b10};
            default: return {3'b100, 1'b1, rd, rs2, 2'b10};
        endcase
    endfunction

    function automatic logic [31:0] long_word();
        logic [31:0] w;
        w = $random(seed);
        w[1:0] = 2'b11;
        // Keep clear of the NOP
        if (w == 32'h0000_0013) w = 32'h0010_0093;
        return w;
    endfunction

    // Mode 0 long only, 1 compressed only, otherwise mixed
    task automatic fill_memory(input int mode);
        int          h;
        bit          want_long;
        logic [31:0] w;
        h = 0;
        while (h < 512) begin
            case (mode)
                0: want_long = 1'b1;
                1: want_long = 1'b0;
                default: want_long = $random(seed) & 1;
            endcase
            if (h == 511) want_long = 1'b0;
            starts[h] = 1'b1;
            if (want_long) begin
                w = long_word();
                halves[h]     = w[15:0];
                halves[h + 1] = w[31:16];
                starts[h + 1] = 1'b0;
                h += 2;
            end else begin
                halves[h] = rvc_word();
                h++;
            end
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = {halves[2 * i + 1], halves[2 * i]};
        end
    endtask

    function automatic int pick_start(input bit need_odd, input bit need_long);
        int base;
        int idx;
        base = $unsigned($random(seed)) % 512;
        for (int i = 0; i < 512; i++) begin
            idx = (base + i) % 512;
            if (starts[idx] && (!need_odd || idx[0]) &&
                (!need_long || halves[idx][1:0] == 2'b11)) begin
                return idx;
            end
        end
        return 0;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic redirect(input int half_idx);
        @(negedge clk);
        stall            = 1'b0;
        cache_blocking_n = 1'b1;
        branch           = 1'b1;
        branch_target    = 31'(half_idx);
        @(negedge clk);
        branch = 1'b0;
    endtask

    task automatic run_stream(input int count, input bit shake);
        int target;
        target = checked + count;
        while (checked < target) begin
            @(negedge clk);
            if (shake) begin
                stall            = ($random(seed) & 3) == 0;
                cache_blocking_n = ($random(seed) & 3) != 0;
            end
            @(posedge clk);
        end
        @(negedge clk);
        stall            = 1'b1;
        cache_blocking_n = 1'b1;
        // Counts are final once the last output has been compared
        @(posedge clk);
    endtask

    task automatic begin_test(input int id);
        test_id  = id;
        err_base = errors;
    endtask

    task automatic end_test();
        if (errors == err_base) begin
            $display("test %s passed", i_checker.test_label(test_id));
        end else begin
            failed_tests++;
            $display("test %s failed with %0d errors", i_checker.test_label(test_id),
                     errors - err_base);
        end
    endtask

    initial begin
        seed             = 32'h73813871;
        rst              = 1'b0;
        stall            = 1'b1;
        cache_blocking_n = 1'b1;
        branch           = 1'b0;
        branch_target    = '0;
        test_id          = 0;
        failed_tests     = 0;
        // Idle contents until the first test fills the memory
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0], ~i[7:0]};
        end
        repeat (10) @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);

        begin_test(0);
        i_checker.check_idle();
        end_test();

        begin_test(1);
        fill_memory(0);
        redirect(int'(`FETCH_RESET_WORD) * 2);
        run_stream(60, 1'b0);
        end_test();

        begin_test(2);
        fill_memory(1);
        redirect(0);
        run_stream(80, 1'b0);
        end_test();

        begin_test(3);
        fill_memory(2);
        redirect(0);
        run_stream(100, 1'b0);
        end_test();

        // First target starts with a long instruction
        begin_test(4);
        fill_memory(2);
        redirect(pick_start(1'b1, 1'b1));
        run_stream(15, 1'b0);
        repeat (3) begin
            redirect(pick_start(1'b1, 1'b0));
            run_stream(15, 1'b0);
        end
        end_test();

        begin_test(5);
        fill_memory(2);
        redirect(pick_start(1'b0, 1'b0));
        run_stream(150, 1'b1);
        end_test();

        $display("6 tests, %0d failed, %0d instructions checked, %0d errors",
                 failed_tests, checked, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- rv_fetch.f
+incdir+hdl
hdl/rv_fetch_pkg.sv
hdl/rvc_expander.sv
hdl/fetch_address_gen.sv
hdl/fetch_aligner.sv
hdl/rv_fetch_top.sv
verif/fetch_checker.sv
verif/tb_rv_fetch.sv

//--- Bender.yml
package:
  name: rv_fetch

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_fetch_pkg.sv
      - hdl/rvc_expander.sv
      - hdl/fetch_address_gen.sv
      - hdl/fetch_aligner.sv
      - hdl/rv_fetch_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/fetch_checker.sv
      - verif/tb_rv_fetch.sv
